/* hw/strand_pkg.sv */
package strand_pkg;
	localparam int NUM_STRANDS = 4;		// Hardware strands
	localparam int STRAND_W = 2;		// Strand index width
	localparam int NUM_REGS = 16;		// Scalar registers per strand
	localparam int REG_W = 4;		// Register index width
	localparam int DATA_W = 32;		// Datapath width
	localparam int QUEUE_DEPTH = 4;		// Entries per strand queue, also initial credits
	localparam int QUEUE_PTR_W = 2;		// Queue pointer width
	localparam int OPCODE_W = 4;
	localparam int IMM_W = 16;		// Raw immediate, sign-extended on decode

	localparam logic [OPCODE_W-1:0] OP_ADD = 4'd0;
	localparam logic [OPCODE_W-1:0] OP_SUB = 4'd1;
	localparam logic [OPCODE_W-1:0] OP_AND = 4'd2;
	localparam logic [OPCODE_W-1:0] OP_OR = 4'd3;
	localparam logic [OPCODE_W-1:0] OP_XOR = 4'd4;
	localparam logic [OPCODE_W-1:0] OP_ADDI = 4'd5;	// src1 + imm
	localparam logic [OPCODE_W-1:0] OP_HALT = 4'd15;	// Disables issuing strand

	// Instruction word layout, msb first
	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;	// 31:28
		logic [REG_W-1:0] dst;		// 27:24
		logic [REG_W-1:0] src1;		// 23:20
		logic [REG_W-1:0] src2;		// 19:16
		logic [IMM_W-1:0] imm;		// 15:0
	} inst_word_t;

	typedef struct packed {
		logic [STRAND_W-1:0] strand;	// Target strand
		logic [DATA_W-1:0] word;	// Raw instruction
	} inst_req_t;

	typedef struct packed {
		logic [STRAND_W-1:0] strand;
		logic [OPCODE_W-1:0] opcode;
		logic [REG_W-1:0] dst;
		logic [REG_W-1:0] src1;
		logic [REG_W-1:0] src2;
		logic [DATA_W-1:0] imm;		// Already extended
	} decoded_t;

	typedef struct packed {
		logic valid;
		decoded_t dec;
		logic [DATA_W-1:0] op1;		// After bypass
		logic [DATA_W-1:0] op2;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [STRAND_W-1:0] strand;
		logic [REG_W-1:0] dst;
		logic [DATA_W-1:0] value;
	} writeback_t;
endpackage

/* hw/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode
	(input clk,
	input reset,
	input inst_valid,
	input strand_pkg::inst_req_t inst,
	output logic push,
	output strand_pkg::decoded_t decoded);

	import strand_pkg::*;

	inst_word_t word;		// Field view of raw word
	decoded_t next_decoded;

	assign word = inst_word_t'(inst.word);

	always_comb
	begin
		next_decoded.strand = inst.strand;
		next_decoded.opcode = word.opcode;
		next_decoded.dst = word.dst;
		next_decoded.src1 = word.src1;
		next_decoded.src2 = word.src2;
		// Sign-extend 16-bit immediate to datapath width
		next_decoded.imm = {{(DATA_W - IMM_W){word.imm[IMM_W-1]}}, word.imm};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			push <= 1'b0;
		else
			push <= inst_valid;	// Push lands in queue next edge
	end

	always_ff @(posedge clk)
	begin
		if (inst_valid)
			decoded <= next_decoded;	// Hold last word when idle
	end
endmodule

/* hw/strand_queues.sv */
`timescale 1ns/1ps

module strand_queues
	(input clk,
	input reset,
	input push,
	input strand_pkg::decoded_t decoded,
	input [strand_pkg::NUM_STRANDS-1:0] pop,
	output logic [strand_pkg::NUM_STRANDS-1:0] not_empty,
	output strand_pkg::decoded_t [strand_pkg::NUM_STRANDS-1:0] heads,
	output logic [strand_pkg::NUM_STRANDS-1:0] inst_credit);

	import strand_pkg::*;

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_queue
		decoded_t mem [QUEUE_DEPTH];	// Circular storage
		logic [QUEUE_PTR_W-1:0] rd_ptr;
		logic [QUEUE_PTR_W-1:0] wr_ptr;
		logic [QUEUE_PTR_W:0] count;	// 0..QUEUE_DEPTH
		logic do_push;
		logic do_pop;

		// Entry steered by its own strand field
		assign do_push = push && decoded.strand == STRAND_W'(s);
		assign do_pop = pop[s] && not_empty[s];	// Ignore pop on empty

		always_ff @(posedge clk)
		begin
			if (do_push)
				mem[wr_ptr] <= decoded;
		end

		always_ff @(posedge clk, posedge reset)
		begin
			if (reset)
			begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (do_push)
					wr_ptr <= wr_ptr + 1'b1;	// Wraps at depth
				if (do_pop)
					rd_ptr <= rd_ptr + 1'b1;
				if (do_push && !do_pop)
					count <= count + 1'b1;
				else if (do_pop && !do_push)
					count <= count - 1'b1;
			end
		end

		assign not_empty[s] = count != '0;
		assign heads[s] = mem[rd_ptr];	// Head visible before pop
		assign inst_credit[s] = do_pop;	// One credit back per pop
	end
endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file
	(input clk,
	input [strand_pkg::STRAND_W-1:0] rd_strand,
	input [strand_pkg::REG_W-1:0] rd_sel1,
	input [strand_pkg::REG_W-1:0] rd_sel2,
	output logic [strand_pkg::DATA_W-1:0] rd_value1,
	output logic [strand_pkg::DATA_W-1:0] rd_value2,
	input strand_pkg::writeback_t wb,
	input reset);

	import strand_pkg::*;

	logic [DATA_W-1:0] regs [NUM_STRANDS][NUM_REGS];	// Per-strand banks

	// Async read, same cycle as strand pick
	assign rd_value1 = regs[rd_strand][rd_sel1];
	assign rd_value2 = regs[rd_strand][rd_sel2];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				for (int r = 0; r < NUM_REGS; r++)
					regs[s][r] <= '0;	// All registers start at zero
			end
		end
		else if (wb.valid)
			regs[wb.strand][wb.dst] <= wb.value;
	end
endmodule

/* hw/strand_select.sv */
`timescale 1ns/1ps

module strand_select
	(input clk,
	input reset,
	input [strand_pkg::NUM_STRANDS-1:0] not_empty,
	input strand_pkg::decoded_t [strand_pkg::NUM_STRANDS-1:0] heads,
	input [strand_pkg::NUM_STRANDS-1:0] strand_enable,
	input strand_pkg::writeback_t wb,
	output logic [strand_pkg::NUM_STRANDS-1:0] pop,
	output logic [strand_pkg::STRAND_W-1:0] rd_strand,
	output logic [strand_pkg::REG_W-1:0] rd_sel1,
	output logic [strand_pkg::REG_W-1:0] rd_sel2,
	input [strand_pkg::DATA_W-1:0] rd_value1,
	input [strand_pkg::DATA_W-1:0] rd_value2,
	output strand_pkg::issue_t issue);

	import strand_pkg::*;

	logic [STRAND_W-1:0] last_strand;	// Last strand that issued
	logic [STRAND_W-1:0] pick;
	logic [STRAND_W-1:0] idx;
	logic pick_valid;
	logic [NUM_STRANDS-1:0] halt_block;	// Own HALT still in issue reg
	logic [NUM_STRANDS-1:0] ready;
	decoded_t head;
	logic [DATA_W-1:0] op1;
	logic [DATA_W-1:0] op2;

	assign halt_block = (issue.valid && issue.dec.opcode == OP_HALT)
		? NUM_STRANDS'(1) << issue.dec.strand : '0;
	assign ready = strand_enable & not_empty & ~halt_block;

	// Round robin, search starts one past last issuer
	always_comb
	begin
		pick_valid = 1'b0;
		pick = last_strand;
		idx = last_strand;
		for (int i = 1; i <= NUM_STRANDS; i++)
		begin
			idx = last_strand + STRAND_W'(i);
			if (!pick_valid && ready[idx])
			begin
				pick_valid = 1'b1;
				pick = idx;
			end
		end
	end

	assign head = heads[pick];
	assign pop = pick_valid ? NUM_STRANDS'(1) << pick : '0;
	assign rd_strand = pick;
	assign rd_sel1 = head.src1;
	assign rd_sel2 = head.src2;

	// Result about to be written this edge
	assign op1 = (wb.valid && wb.strand == pick && wb.dst == head.src1) ? wb.value : rd_value1;
	assign op2 = (wb.valid && wb.strand == pick && wb.dst == head.src2) ? wb.value : rd_value2;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			issue <= '0;
			last_strand <= '0;
		end
		else
		begin
			issue <= '{valid: pick_valid, dec: head, op1: op1, op2: op2};
			if (pick_valid)
				last_strand <= pick;
		end
	end
endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
	(input clk,
	input reset,
	input strand_pkg::issue_t issue,
	output strand_pkg::writeback_t wb,
	output logic [strand_pkg::NUM_STRANDS-1:0] strand_enable,
	output logic result_valid,
	output strand_pkg::writeback_t result,
	output logic halt);

	import strand_pkg::*;

	logic [DATA_W-1:0] alu_value;
	logic alu_op;		// Opcode produces a register result
	logic is_halt;

	always_comb
	begin
		alu_op = 1'b1;
		case (issue.dec.opcode)
			OP_ADD: alu_value = issue.op1 + issue.op2;
			OP_SUB: alu_value = issue.op1 - issue.op2;
			OP_AND: alu_value = issue.op1 & issue.op2;
			OP_OR: alu_value = issue.op1 | issue.op2;
			OP_XOR: alu_value = issue.op1 ^ issue.op2;
			OP_ADDI: alu_value = issue.op1 + issue.dec.imm;
			default:
			begin
				// HALT and undefined opcodes, no writeback
				alu_value = '0;
				alu_op = 1'b0;
			end
		endcase
	end

	// Feeds register file and bypass same cycle
	assign wb = '{valid: issue.valid && alu_op, strand: issue.dec.strand,
		dst: issue.dec.dst, value: alu_value};

	assign is_halt = issue.valid && issue.dec.opcode == OP_HALT;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			strand_enable <= '1;	// All strands run out of reset
		else if (is_halt)
			strand_enable[issue.dec.strand] <= 1'b0;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result <= '0;
			halt <= 1'b0;
		end
		else
		begin
			result_valid <= wb.valid;
			result <= wb;		// No back-pressure on results
			halt <= strand_enable == '0;	// Every strand disabled
		end
	end
endmodule

/* hw/strand_pipeline.sv */
`timescale 1ns/1ps

module strand_pipeline
	(input clk,
	input reset,
	input inst_valid,
	input strand_pkg::inst_req_t inst,
	output logic [strand_pkg::NUM_STRANDS-1:0] inst_credit,
	output logic result_valid,
	output strand_pkg::writeback_t result,
	output logic halt);

	import strand_pkg::*;

	logic push;			// Decode to queue
	decoded_t decoded;
	logic [NUM_STRANDS-1:0] pop;
	logic [NUM_STRANDS-1:0] not_empty;
	decoded_t [NUM_STRANDS-1:0] heads;
	logic [STRAND_W-1:0] rd_strand;
	logic [REG_W-1:0] rd_sel1;
	logic [REG_W-1:0] rd_sel2;
	logic [DATA_W-1:0] rd_value1;
	logic [DATA_W-1:0] rd_value2;
	issue_t issue;			// Select to execute
	writeback_t wb;			// Execute to regfile and bypass
	logic [NUM_STRANDS-1:0] strand_enable;

	instruction_decode instruction_decode(.clk(clk), .reset(reset), .inst_valid(inst_valid),
		.inst(inst), .push(push), .decoded(decoded));

	strand_queues strand_queues(.clk(clk), .reset(reset), .push(push), .decoded(decoded),
		.pop(pop), .not_empty(not_empty), .heads(heads), .inst_credit(inst_credit));

	strand_select strand_select(.clk(clk), .reset(reset), .not_empty(not_empty),
		.heads(heads), .strand_enable(strand_enable), .wb(wb), .pop(pop),
		.rd_strand(rd_strand), .rd_sel1(rd_sel1), .rd_sel2(rd_sel2),
		.rd_value1(rd_value1), .rd_value2(rd_value2), .issue(issue));

	register_file register_file(.clk(clk), .rd_strand(rd_strand), .rd_sel1(rd_sel1),
		.rd_sel2(rd_sel2), .rd_value1(rd_value1), .rd_value2(rd_value2), .wb(wb),
		.reset(reset));

	execute_stage execute_stage(.clk(clk), .reset(reset), .issue(issue), .wb(wb),
		.strand_enable(strand_enable), .result_valid(result_valid), .result(result),
		.halt(halt));
endmodule

/* test/strand_pipeline_asserts.sv */
`timescale 1ns/1ps

module strand_pipeline_asserts
	(input clk,
	input reset,
	input push,
	input strand_pkg::decoded_t decoded,
	input [strand_pkg::NUM_STRANDS-1:0] pop,
	input [strand_pkg::NUM_STRANDS-1:0] inst_credit);

	import strand_pkg::*;

	logic [QUEUE_PTR_W:0] fill [NUM_STRANDS];	// Shadow occupancy per queue
	logic [NUM_STRANDS-1:0] push_hit;
	logic [NUM_STRANDS-1:0] pop_hit;

	always_comb
	begin
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			push_hit[s] = push && decoded.strand == STRAND_W'(s);
			pop_hit[s] = pop[s] && fill[s] != '0;	// Pop the shadow count allows
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				fill[s] <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (push_hit[s] && !pop_hit[s])
					fill[s] <= fill[s] + 1'b1;
				else if (pop_hit[s] && !push_hit[s])
					fill[s] <= fill[s] - 1'b1;
			end
		end
	end

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_check
		a_no_overflow: assert property (@(posedge clk) disable iff (reset)
			push_hit[s] |-> fill[s] != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH))
			else $error("Push into full queue %0d", s);
		a_no_underflow: assert property (@(posedge clk) disable iff (reset)
			pop[s] |-> fill[s] != '0)
			else $error("Pop from empty queue %0d", s);
		a_credit_on_pop: assert property (@(posedge clk) disable iff (reset)
			inst_credit[s] == pop_hit[s])
			else $error("Credit pulse without a matching pop on strand %0d", s);
	end
endmodule

bind strand_queues strand_pipeline_asserts queue_checks(.clk(clk), .reset(reset), .push(push),
	.decoded(decoded), .pop(pop), .inst_credit(inst_credit));

/* test/strand_pipeline_tb.sv */
`timescale 1ns/1ps

module strand_pipeline_tb;
	import strand_pkg::*;

	localparam int TIMEOUT = 200;		// Cycles allowed per wait loop

	logic clk;
	logic reset;
	logic inst_valid;
	inst_req_t inst;
	logic [NUM_STRANDS-1:0] inst_credit;
	logic result_valid;
	writeback_t result;
	logic halt;

	logic [31:0] lfsr;			// Stimulus state
	int credits [NUM_STRANDS];		// Sender side credits
	int credit_pulses [NUM_STRANDS];	// Pulses seen since reset
	logic [DATA_W-1:0] model_regs [NUM_STRANDS][NUM_REGS];
	logic [NUM_STRANDS-1:0] model_halted;
	writeback_t exp_q [NUM_STRANDS][$];	// Expected results, oldest first
	int mismatches;
	int failures;

	strand_pipeline UUT(.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.inst_credit(inst_credit), .result_valid(result_valid), .result(result), .halt(halt));

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [DATA_W-1:0] alu_model(input logic [3:0] op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [15:0] imm);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_ADDI: return a + {{16{imm[15]}}, imm};
			default: return '0;
		endcase
	endfunction

	function automatic int pending();
		int total;
		total = 0;
		for (int s = 0; s < NUM_STRANDS; s++)
			total += exp_q[s].size();
		return total;
	endfunction

	// Called and returns at posedge + 1
	task automatic send(input int s, input logic [3:0] op, input logic [3:0] dst,
		input logic [3:0] src1, input logic [3:0] src2, input logic [15:0] imm);
		writeback_t expected;
		int t;
		t = 0;
		while (credits[s] == 0 && t < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (credits[s] > 0) else
		begin
			$display("No credit came back for strand %0d, instruction dropped", s);
			failures++;
		end
		if (credits[s] > 0)
		begin
			inst_valid = 1'b1;
			inst.strand = STRAND_W'(s);
			inst.word = {op, dst, src1, src2, imm};
			credits[s]--;
			if (!model_halted[s])
			begin
				if (op == OP_HALT)
					model_halted[s] = 1'b1;
				else if (op <= OP_ADDI)		// Other opcodes do nothing
				begin
					expected.valid = 1'b1;
					expected.strand = STRAND_W'(s);
					expected.dst = dst;
					expected.value = alu_model(op, model_regs[s][src1], model_regs[s][src2], imm);
					model_regs[s][dst] = expected.value;
					exp_q[s].push_back(expected);
				end
			end
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (pending() != 0 && t < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (pending() == 0) else
		begin
			$display("Timed out with %0d results still outstanding", pending());
			failures++;
		end
	endtask

	task automatic wait_credits(input int s);
		int t;
		t = 0;
		while (credits[s] != QUEUE_DEPTH && t < TIMEOUT)
		begin
			@(posedge clk);
			#1;
			t++;
		end
		assert (credits[s] == QUEUE_DEPTH) else
		begin
			$display("Timed out waiting for all credits of strand %0d", s);
			failures++;
		end
	endtask

	task automatic check_quiet();
		assert (!result_valid && !halt && inst_credit == '0) else
		begin
			$display("Outputs active around reset: result_valid %b halt %b inst_credit %b",
				result_valid, halt, inst_credit);
			failures++;
		end
	endtask

	// Results and credits sampled mid-cycle
	always @(negedge clk)
	begin
		writeback_t expected;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (inst_credit[s])
			begin
				credits[s]++;
				credit_pulses[s]++;
			end
		end
		assert (!halt || model_halted == '1) else
		begin
			$display("halt went high while a strand was still enabled");
			failures++;
		end
		if (result_valid)
		begin
			assert (exp_q[result.strand].size() > 0) else
			begin
				$display("Unexpected result on strand %0d", result.strand);
				failures++;
			end
			if (exp_q[result.strand].size() > 0)
			begin
				expected = exp_q[result.strand].pop_front();
				assert (result.valid == expected.valid && result.dst == expected.dst
					&& result.value == expected.value) else
				begin
					$display("Mismatch result strand %0d: valid %h dst %h value %h, expected %h %h %h",
						result.strand, result.valid, result.dst, result.value,
						expected.valid, expected.dst, expected.value);
					mismatches++;
				end
			end
		end
	end

	task automatic test_reset();
		repeat (16)
		begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#1;
	endtask

	task automatic test_latency_bypass();
		int n;
		send(0, OP_ADDI, 4'd1, 4'd0, 4'd0, 16'(lfsr_bits(16)));
		n = 0;
		while (!result_valid && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		assert (n - 1 == 3) else	// First negedge follows the accepting edge
		begin
			$display("Mismatch result_valid latency: got %h expected %h", n - 1, 3);
			mismatches++;
		end
		@(posedge clk);
		#1;
		for (int i = 2; i <= 6; i++)
			send(0, OP_ADDI, 4'(i), 4'(i - 1), 4'd0, 16'(lfsr_bits(16)));
		// Chain ADD..XOR, src2 reads the previous dst
		for (int i = 0; i < 5; i++)
			send(0, 4'(i), 4'(i + 7), 4'(i + 1), 4'(i + 6), 16'h0000);
		wait_drain();
	endtask

	task automatic test_interleaved();
		logic [3:0] op;
		for (int i = 0; i < 32; i++)
		begin
			op = 4'(lfsr_bits(3) % 6);	// ADD through ADDI
			send(i % NUM_STRANDS, op, 4'(lfsr_bits(4)), 4'(lfsr_bits(4)), 4'(lfsr_bits(4)),
				16'(lfsr_bits(16)));
		end
		wait_drain();
	endtask

	task automatic test_credits();
		int base;
		wait_credits(1);
		base = credit_pulses[1];
		for (int i = 0; i < QUEUE_DEPTH; i++)
			send(1, OP_ADDI, 4'(i + 1), 4'(i), 4'd0, 16'(lfsr_bits(16)));
		wait_drain();
		wait_credits(1);
		assert (credit_pulses[1] - base == QUEUE_DEPTH) else
		begin
			$display("Mismatch inst_credit[1] pulses: got %h expected %h",
				credit_pulses[1] - base, QUEUE_DEPTH);
			mismatches++;
		end
	endtask

	task automatic test_halt();
		int t;
		send(3, 4'd7, 4'd2, 4'd1, 4'd1, 16'h1234);	// Undefined opcode
		send(3, OP_ADDI, 4'd3, 4'd2, 4'd0, 16'h0001);	// r2 must be unchanged
		wait_drain();
		idle(4);
		send(3, OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
		// Queued right behind HALT, none may issue
		for (int i = 0; i < QUEUE_DEPTH; i++)
			send(3, OP_ADDI, 4'(i + 4), 4'd3, 4'd0, 16'(lfsr_bits(16)));
		idle(10);
		assert (credits[3] == 0) else
		begin
			$display("Halted strand 3 still returns credits");
			failures++;
		end
		send(0, OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
		send(1, OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
		idle(6);
		assert (!halt) else
		begin
			$display("halt is high with strand 2 still running");
			failures++;
		end
		send(2, OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0000);
		t = 0;
		while (!halt && t < TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		assert (halt) else
		begin
			$display("halt never rose after all four strands halted");
			failures++;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		lfsr = 32'ha4c3;
		mismatches = 0;
		failures = 0;
		model_halted = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			credits[s] = QUEUE_DEPTH;
			credit_pulses[s] = 0;
			for (int r = 0; r < NUM_REGS; r++)
				model_regs[s][r] = '0;
		end
		test_reset();
		test_latency_bypass();
		test_interleaved();
		test_credits();
		test_halt();
		$display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

/* src.f */
hw/strand_pkg.sv
hw/instruction_decode.sv
hw/strand_queues.sv
hw/register_file.sv
hw/strand_select.sv
hw/execute_stage.sv
hw/strand_pipeline.sv
test/strand_pipeline_asserts.sv
test/strand_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module strand_pipeline_tb -f src.f -o strand_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/strand_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Testbench reported failure"
	exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
